/* build.f */
+incdir+include
logic/branch_pkg.sv
logic/btb_table.sv
logic/branch_dispatch.sv
logic/branch_unit.sv
logic/branch_cluster.sv
sim/branch_tb.sv

/* Bender.yml */
package:
  name: branch_cluster

sources:
  - files:
      - logic/branch_pkg.sv
      - logic/btb_table.sv
      - logic/branch_dispatch.sv
      - logic/branch_unit.sv
      - logic/branch_cluster.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/branch_tb.sv

/* include/branch_tb_checks.svh */
`ifndef BRANCH_TB_CHECKS_SVH
`define BRANCH_TB_CHECKS_SVH

int error_count = 0;
int check_count = 0;

task automatic check_word(input string what, input branch_pkg::word_t got,
                          input branch_pkg::word_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("ERROR %s: got %08h, expected %08h at %0t", what, got, exp, $time);
    end
endtask

task automatic check_preg(input string what, input branch_pkg::preg_t got,
                          input branch_pkg::preg_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("ERROR %s: got x%0d, expected x%0d at %0t", what, got, exp, $time);
    end
endtask

task automatic check_rob(input string what, input branch_pkg::rob_id_t got,
                         input branch_pkg::rob_id_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("ERROR %s: got tag %0d, expected %0d at %0t", what, got, exp, $time);
    end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("ERROR %s: got %b, expected %b at %0t", what, got, exp, $time);
    end
endtask

// Closing line of the run
task automatic report_counts();
    $display("%0d checks, %0d errors", check_count, error_count);
endtask

`endif

/* sim/branch_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_tb;

    typedef struct packed {
        branch_pkg::resolve_t res;
        logic                 ready;    // op_ready_o in the result cycle
    } seen_t;

    typedef struct packed {
        logic                 valid;
        branch_pkg::pc_word_t pc;
        branch_pkg::word_t    target;
        branch_pkg::btype_t   btype;
        branch_pkg::bm_cntr_t cntr;
    } model_t;

    localparam int SETS = 64;
    // Reset, then the six tests
    localparam int MAX_CYCLES = 2 * (10 + 40 + 220 + 30 + 40 + 30 + 40);

    logic                   cpu_clock_i = 1'b0;
    logic                   reset_i;
    logic                   flush_i;
    logic                   op_valid_i;
    logic                   op_ready_o;
    logic                   res_valid_o;
    branch_pkg::branch_op_t op_i;
    branch_pkg::resolve_t   res_o;

    seen_t                  seen_q[$];
    branch_pkg::branch_op_t sent_q[$];
    model_t                 model_q [SETS];    // Tests keep one PC per set
    int                     cycle_count = 0;
    int                     next_set = 0;
    branch_pkg::rob_id_t    next_rob = '0;

    `include "branch_tb_checks.svh"

    branch_cluster #(.BTB_SETS(SETS)) UUT (.*);

    always #5 cpu_clock_i = !cpu_clock_i;

    always @(negedge cpu_clock_i) begin
        if (res_valid_o) begin
            seen_q.push_back({res_o, op_ready_o});
        end
    end

    task automatic finish_run();
        report_counts();
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    always @(posedge cpu_clock_i) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            error_count++;
            finish_run();
        end
    end

    function automatic logic cond_holds(input logic [2:0] f3, input branch_pkg::word_t a,
                                        input branch_pkg::word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Kind is {auipc, lui, jal, jalr}
    function automatic branch_pkg::branch_op_t make_op(input branch_pkg::pc_word_t pc,
            input logic [3:0] kind, input logic [2:0] f3, input branch_pkg::word_t a,
            input branch_pkg::word_t b, input branch_pkg::word_t off,
            input branch_pkg::preg_t dest);
        branch_pkg::branch_op_t op;
        op = '0;
        op.pc = pc;
        {op.auipc, op.lui, op.jal, op.jalr} = kind;
        op.bnch_cond = f3;
        op.operand_1 = a;
        op.operand_2 = b;
        op.offset = off;
        op.dest = dest;
        op.rob_id = next_rob;
        next_rob++;
        return op;
    endfunction

    function automatic branch_pkg::pc_word_t fresh_pc();
        next_set++;
        return 30'h0040_0000 + 30'(next_set);
    endfunction

    // Expected result from the BTB model, then train the model
    task automatic model_op(input branch_pkg::branch_op_t op, output branch_pkg::resolve_t want);
        model_t             ent;
        branch_pkg::word_t  pcb;
        branch_pkg::word_t  tgt;
        branch_pkg::btype_t btype;
        logic               upper;
        logic               jump;
        logic               taken;
        logic               hit;
        pcb   = {op.pc, 2'b00};
        upper = op.lui || op.auipc;
        jump  = op.jal || op.jalr;
        btype = jump ? branch_pkg::BTYPE_JUMP : branch_pkg::BTYPE_COND;
        taken = jump || (!upper && cond_holds(op.bnch_cond, op.operand_1, op.operand_2));
        tgt   = (op.jalr ? op.operand_1 : pcb) + op.offset;
        ent   = model_q[op.pc % SETS];
        hit   = ent.valid && (ent.pc == op.pc);
        want.result   = op.lui ? op.offset : (op.auipc ? pcb + op.offset : pcb + 32'd4);
        want.wb_valid = (upper || jump) && (op.dest != '0);
        want.dest     = op.dest;
        want.rob_id   = op.rob_id;
        want.excp     = !upper && (!hit || ent.btype != btype || (taken && ent.target != tgt)
                                   || (!jump && ent.cntr[1] != taken));
        if (!upper) begin
            if (jump) begin
                ent.cntr = 2'b11;
            end else if (!hit) begin
                ent.cntr = taken ? 2'b10 : 2'b01;    // Weak, toward outcome
            end else if (taken && ent.cntr != 2'b11) begin
                ent.cntr = ent.cntr + 2'b01;
            end else if (!taken && ent.cntr != 2'b00) begin
                ent.cntr = ent.cntr - 2'b01;
            end
            model_q[op.pc % SETS] = '{valid: 1'b1, pc: op.pc, target: tgt, btype: btype,
                                      cntr: ent.cntr};
        end
    endtask

    task automatic send_op(input branch_pkg::branch_op_t op);
        op_i       = op;
        op_valid_i = 1'b1;
        while (!op_ready_o) begin    // Held off during a BTB write
            @(posedge cpu_clock_i);
            #1;
        end
        @(posedge cpu_clock_i);
        #1;
        sent_q.push_back(op);
    endtask

    task automatic collect_one(input string name);
        branch_pkg::branch_op_t op;
        branch_pkg::resolve_t   want;
        seen_t                  got;
        while (seen_q.size() == 0) begin
            @(posedge cpu_clock_i);
            #1;
        end
        got = seen_q.pop_front();
        op  = sent_q.pop_front();
        model_op(op, want);
        check_word({name, " result"}, got.res.result, want.result);
        check_flag({name, " wb_valid"}, got.res.wb_valid, want.wb_valid);
        check_preg({name, " dest"}, got.res.dest, want.dest);
        check_rob({name, " rob_id"}, got.res.rob_id, want.rob_id);
        check_flag({name, " excp"}, got.res.excp, want.excp);
        // Branches and jumps write the BTB in their result cycle
        check_flag({name, " op_ready_o"}, got.ready, op.lui || op.auipc);
    endtask

    task automatic run_op(input string name, input branch_pkg::branch_op_t op);
        send_op(op);
        op_valid_i = 1'b0;
        collect_one(name);
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        repeat (cycles) @(posedge cpu_clock_i);
        #1;
        if (seen_q.size() != 0) begin
            error_count++;
            $display("ERROR %s: expected no further result, got %0d", name, seen_q.size());
            seen_q.delete();
        end
    endtask

    task automatic upper_ops();
        for (int i = 0; i < 4; i++) begin
            run_op("lui", make_op(30'($urandom()), 4'b0100, 3'd0, '0, '0, $urandom(),
                                  branch_pkg::preg_t'(i * 9)));
            run_op("auipc", make_op(30'($urandom()), 4'b1000, 3'd0, '0, '0, $urandom(),
                                    branch_pkg::preg_t'(27 - i * 9)));
        end
    endtask

    task automatic branch_conditions();
        logic [2:0]             f3 [6];
        branch_pkg::word_t      a [4];
        branch_pkg::word_t      b [4];
        branch_pkg::branch_op_t op;
        f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        a[0] = 32'h8000_0000;    // Most negative against most positive
        b[0] = 32'h7fff_ffff;
        a[1] = 32'hffff_ffff;
        b[1] = 32'h0000_0001;
        for (int c = 0; c < 6; c++) begin
            a[2] = $urandom();
            b[2] = a[2];
            a[3] = $urandom();
            b[3] = $urandom();
            for (int k = 0; k < 4; k++) begin
                op = make_op(fresh_pc(), 4'b0000, f3[c], a[k], b[k],
                             $urandom() & 32'hffff_fffc, branch_pkg::preg_t'($urandom()));
                run_op($sformatf("cond %03b case %0d first", f3[c], k), op);
                run_op($sformatf("cond %03b case %0d repeat", f3[c], k), op);
            end
        end
    endtask

    task automatic jump_links();
        branch_pkg::branch_op_t op;
        op = make_op(fresh_pc(), 4'b0010, 3'd0, '0, '0, 32'h0000_0200, 6'd1);
        run_op("jal first", op);
        run_op("jal repeat", op);
        op = make_op(fresh_pc(), 4'b0001, 3'd0, $urandom() & 32'hffff_fffc, '0, 32'h10, 6'd5);
        run_op("jalr first", op);
        run_op("jalr repeat", op);
        op.operand_1 = op.operand_1 + 32'h100;    // New target
        run_op("jalr new base", op);
        run_op("jalr retrained", op);
    endtask

    task automatic counter_training();
        logic [8:0]             outcome;
        branch_pkg::branch_op_t op;
        outcome = 9'b001010111;    // Bit 0 first
        op = make_op(fresh_pc(), 4'b0000, 3'b000, 32'h1234_5678, '0, 32'h40, 6'd0);
        for (int i = 0; i < 9; i++) begin
            op.operand_2 = outcome[i] ? op.operand_1 : ~op.operand_1;
            run_op($sformatf("counter step %0d", i), op);
        end
    endtask

    task automatic flush_in_flight();
        branch_pkg::branch_op_t op_a;
        op_a = make_op(fresh_pc(), 4'b0000, 3'b001, 32'h1, 32'h2, 32'h80, 6'd0);
        send_op(op_a);
        send_op(make_op(fresh_pc(), 4'b0010, 3'd0, '0, '0, 32'h100, 6'd3));
        op_valid_i = 1'b0;
        flush_i    = 1'b1;    // Both operations still in flight
        @(posedge cpu_clock_i);
        #1;
        flush_i = 1'b0;
        sent_q.delete();
        expect_quiet("flush", 6);
        run_op("after flush", op_a);
    endtask

    task automatic back_to_back();
        send_op(make_op(fresh_pc(), 4'b0000, 3'b110, $urandom(), $urandom(), 32'h100, 6'd0));
        send_op(make_op(30'($urandom()), 4'b0100, 3'd0, '0, '0, $urandom(), 6'd7));
        send_op(make_op(fresh_pc(), 4'b0010, 3'd0, '0, '0, 32'hffff_ff00, 6'd8));
        send_op(make_op(fresh_pc(), 4'b0000, 3'b101, $urandom(), $urandom(), 32'h40, 6'd0));
        send_op(make_op(30'($urandom()), 4'b1000, 3'd0, '0, '0, $urandom(), 6'd9));
        send_op(make_op(fresh_pc(), 4'b0001, 3'd0, $urandom() & 32'hffff_fffc, '0, 32'h20,
                        6'd10));
        op_valid_i = 1'b0;
        for (int i = 0; i < 6; i++) begin
            collect_one($sformatf("stream %0d", i));
        end
        expect_quiet("stream", 5);
    endtask

    initial begin
        void'($urandom(16));
        reset_i    = 1'b1;
        flush_i    = 1'b0;
        op_valid_i = 1'b0;
        op_i       = '0;
        for (int s = 0; s < SETS; s++) begin
            model_q[s] = '0;
        end
        repeat (10) @(posedge cpu_clock_i);
        #1;
        reset_i = 1'b0;
        check_flag("reset op_ready_o", op_ready_o, 1'b1);
        check_flag("reset res_valid_o", res_valid_o, 1'b0);
        check_flag("reset wb_valid", res_o.wb_valid, 1'b0);
        check_flag("reset excp", res_o.excp, 1'b0);
        upper_ops();
        branch_conditions();
        jump_links();
        counter_training();
        flush_in_flight();
        back_to_back();
        finish_run();
    end

endmodule

`default_nettype wire

/* logic/branch_cluster.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_cluster #(
    parameter int BTB_SETS = 64
) (
    input   wire logic                      cpu_clock_i,
    input   wire logic                      reset_i,
    input   wire logic                      flush_i,
    input   wire branch_pkg::branch_op_t    op_i,
    input   wire logic                      op_valid_i,
    output  logic                           op_ready_o,
    output  branch_pkg::resolve_t           res_o,
    output  logic                           res_valid_o
);

    branch_pkg::pc_word_t    lookup_vpc;
    branch_pkg::btb_pred_t   pred;
    branch_pkg::branch_op_t  issue_op;
    branch_pkg::btb_pred_t   issue_pred;
    logic                    issue_valid;
    branch_pkg::btb_update_t upd;
    logic                    btb_busy;

    branch_dispatch u_dispatch (
        .cpu_clock_i   (cpu_clock_i),
        .reset_i       (reset_i),
        .flush_i       (flush_i),
        .op_i          (op_i),
        .op_valid_i    (op_valid_i),
        .op_ready_o    (op_ready_o),
        .btb_busy_i    (btb_busy),
        .lookup_vpc_o  (lookup_vpc),
        .pred_i        (pred),
        .issue_op_o    (issue_op),
        .issue_pred_o  (issue_pred),
        .issue_valid_o (issue_valid)
    );

    btb_table #(
        .BTB_SETS (BTB_SETS)
    ) u_btb (
        .cpu_clock_i  (cpu_clock_i),
        .reset_i      (reset_i),
        .lookup_vpc_i (lookup_vpc),
        .pred_o       (pred),
        .upd_i        (upd),
        .busy_o       (btb_busy)
    );

    branch_unit u_branch (
        .cpu_clock_i (cpu_clock_i),
        .reset_i     (reset_i),
        .flush_i     (flush_i),
        .op_i        (issue_op),
        .pred_i      (issue_pred),
        .valid_i     (issue_valid),
        .res_o       (res_o),
        .res_valid_o (res_valid_o),
        .upd_o       (upd)
    );

endmodule

`default_nettype wire

/* logic/branch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_unit (
    input   wire logic                      cpu_clock_i,
    input   wire logic                      reset_i,
    input   wire logic                      flush_i,
    input   wire branch_pkg::branch_op_t    op_i,
    input   wire branch_pkg::btb_pred_t     pred_i,
    input   wire logic                      valid_i,
    output  branch_pkg::resolve_t           res_o,
    output  logic                           res_valid_o,
    output  branch_pkg::btb_update_t        upd_o
);

    branch_pkg::word_t  pc_byte;
    branch_pkg::word_t  link_addr;
    branch_pkg::word_t  taken_target;
    branch_pkg::word_t  next_addr;
    branch_pkg::word_t  result;
    branch_pkg::btype_t actual_type;

    logic eq;
    logic gt_low;
    logic gt_s;
    logic gt_u;
    logic gt;
    logic lt;
    logic cond_true;
    logic is_jump;
    logic is_upper;
    logic taken;
    logic wrong_miss;
    logic wrong_target;
    logic wrong_type;
    logic wrong_cntr;
    logic mispredict;
    logic fire;

    assign is_jump  = op_i.jal || op_i.jalr;
    assign is_upper = op_i.lui || op_i.auipc;

    // Compare split into sign bits and 31-bit magnitude
    assign eq     = op_i.operand_1 == op_i.operand_2;
    assign gt_low = op_i.operand_1[30:0] > op_i.operand_2[30:0];

    always_comb begin
        if (op_i.operand_1[31] == op_i.operand_2[31]) begin
            gt_s = gt_low;
            gt_u = gt_low;
        end else begin
            gt_s = !op_i.operand_1[31];    // Non-negative beats negative
            gt_u = op_i.operand_1[31];
        end
    end

    assign gt = op_i.bnch_cond[1] ? gt_u : gt_s;
    assign lt = !(gt || eq);

    always_comb begin
        case ({op_i.bnch_cond[2], op_i.bnch_cond[0]})
            2'b00:   cond_true = eq;     // beq
            2'b01:   cond_true = !eq;    // bne
            2'b10:   cond_true = lt;     // blt, bltu
            default: cond_true = !lt;    // bge, bgeu
        endcase
    end

    assign taken = is_jump || (cond_true && !is_upper);

    assign pc_byte      = {op_i.pc, 2'b00};
    assign link_addr    = pc_byte + 32'd4;
    assign taken_target = (op_i.jalr ? op_i.operand_1 : pc_byte) + op_i.offset;
    assign next_addr    = taken ? taken_target : link_addr;

    always_comb begin
        if (op_i.lui) begin
            result = op_i.offset;
        end else if (op_i.auipc) begin
            result = pc_byte + op_i.offset;
        end else begin
            result = link_addr;
        end
    end

    assign actual_type = is_jump ? branch_pkg::BTYPE_JUMP : branch_pkg::BTYPE_COND;

    // Any of these means the front end went the wrong way
    assign wrong_miss   = !pred_i.hit;
    assign wrong_target = pred_i.hit && taken && ({pred_i.target, 2'b00} != next_addr);
    assign wrong_type   = pred_i.hit && (pred_i.btype != actual_type);
    assign wrong_cntr   = pred_i.hit && !is_jump && (pred_i.cntr[1] != taken);
    assign mispredict   = !is_upper && (wrong_miss || wrong_target || wrong_type || wrong_cntr);

    assign fire = valid_i && !flush_i;

    always_ff @(posedge cpu_clock_i) begin
        if (reset_i) begin
            res_valid_o    <= 1'b0;
            res_o.wb_valid <= 1'b0;
            res_o.excp     <= 1'b0;
            upd_o.valid    <= 1'b0;
        end else begin
            res_valid_o    <= fire;
            res_o.wb_valid <= fire && (is_upper || is_jump) && (op_i.dest != '0);
            res_o.excp     <= fire && mispredict;
            upd_o.valid    <= fire && !is_upper;
        end
    end

    // Payload, qualified by the valid bits above
    always_ff @(posedge cpu_clock_i) begin
        res_o.result <= result;
        res_o.dest   <= op_i.dest;
        res_o.rob_id <= op_i.rob_id;
        upd_o.vpc    <= op_i.pc;
        upd_o.target <= taken_target;
        upd_o.taken  <= taken;
        upd_o.btype  <= actual_type;
        upd_o.way    <= pred_i.way;
        upd_o.cntr   <= pred_i.cntr;
    end

endmodule

`default_nettype wire

/* logic/branch_dispatch.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_dispatch (
    input   wire logic                      cpu_clock_i,
    input   wire logic                      reset_i,
    input   wire logic                      flush_i,
    // issue port
    input   wire branch_pkg::branch_op_t    op_i,
    input   wire logic                      op_valid_i,
    output  logic                           op_ready_o,
    // BTB read port
    input   wire logic                      btb_busy_i,
    output  branch_pkg::pc_word_t           lookup_vpc_o,
    input   wire branch_pkg::btb_pred_t     pred_i,
    // towards the branch unit
    output  branch_pkg::branch_op_t         issue_op_o,
    output  branch_pkg::btb_pred_t          issue_pred_o,
    output  logic                           issue_valid_o
);

    branch_pkg::branch_op_t lkp_op_q;      // Waiting for its BTB read
    logic                   lkp_valid_q;
    branch_pkg::branch_op_t hold_op_q;     // Read done, prediction on pred_i
    logic                   hold_valid_q;
    logic                   accept;
    logic                   read_fire;

    // Nothing can move while the BTB is writing
    assign op_ready_o = !btb_busy_i;
    assign accept     = op_valid_i && op_ready_o;
    assign read_fire  = lkp_valid_q && !btb_busy_i;

    assign lookup_vpc_o = lkp_op_q.pc;

    always_ff @(posedge cpu_clock_i) begin
        if (reset_i || flush_i) begin
            lkp_valid_q  <= 1'b0;
            hold_valid_q <= 1'b0;
        end else begin
            if (accept) begin
                lkp_valid_q <= 1'b1;
            end else if (read_fire) begin
                lkp_valid_q <= 1'b0;
            end
            hold_valid_q <= read_fire;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (accept) begin
            lkp_op_q <= op_i;
        end
        if (read_fire) begin
            hold_op_q <= lkp_op_q;    // Same edge the BTB registers its read
        end
    end

    assign issue_op_o    = hold_op_q;
    assign issue_pred_o  = pred_i;
    assign issue_valid_o = hold_valid_q;

endmodule

`default_nettype wire

/* logic/btb_table.sv */
`timescale 1ns/10ps
`default_nettype none

module btb_table #(
    parameter int BTB_SETS = 64
) (
    input   wire logic                      cpu_clock_i,
    input   wire logic                      reset_i,
    input   wire branch_pkg::pc_word_t      lookup_vpc_i,
    output  branch_pkg::btb_pred_t          pred_o,
    input   wire branch_pkg::btb_update_t   upd_i,
    output  logic                           busy_o
);

    localparam int IDX_W = $clog2(BTB_SETS);
    localparam int TAG_W = 30 - IDX_W;

    typedef struct packed {
        logic [TAG_W-1:0]     tag;
        branch_pkg::pc_word_t target;
        branch_pkg::btype_t   btype;
        branch_pkg::bm_cntr_t cntr;
    } entry_t;

    entry_t     mem_q   [BTB_SETS][2];
    logic [1:0] valid_q [BTB_SETS];
    logic       repl_q  [BTB_SETS];    // Way to replace next

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [1:0]       rd_match;
    logic             rd_way;
    entry_t           rd_entry;

    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    logic [1:0]       wr_match;
    logic             wr_hit;
    logic             wr_way;
    branch_pkg::bm_cntr_t wr_cntr;

    // Single port, a pending write owns it
    assign busy_o = upd_i.valid;

    assign rd_idx = lookup_vpc_i[IDX_W-1:0];
    assign rd_tag = lookup_vpc_i[29:IDX_W];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            rd_match[w] = valid_q[rd_idx][w] && (mem_q[rd_idx][w].tag == rd_tag);
        end
        rd_way   = rd_match[1];
        rd_entry = mem_q[rd_idx][rd_way];
    end

    assign wr_idx = upd_i.vpc[IDX_W-1:0];
    assign wr_tag = upd_i.vpc[29:IDX_W];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wr_match[w] = valid_q[wr_idx][w] && (mem_q[wr_idx][w].tag == wr_tag);
        end
        wr_hit = |wr_match;
        if (wr_match[upd_i.way]) begin
            wr_way = upd_i.way;
        end else if (wr_match[!upd_i.way]) begin
            wr_way = !upd_i.way;
        end else begin
            wr_way = repl_q[wr_idx];
        end
    end

    // Bimodal counter training
    always_comb begin
        if (upd_i.btype == branch_pkg::BTYPE_JUMP) begin
            wr_cntr = 2'b11;
        end else if (!wr_hit) begin
            wr_cntr = upd_i.taken ? 2'b10 : 2'b01;    // Weak, toward outcome
        end else if (upd_i.taken) begin
            wr_cntr = (upd_i.cntr == 2'b11) ? 2'b11 : upd_i.cntr + 2'b01;
        end else begin
            wr_cntr = (upd_i.cntr == 2'b00) ? 2'b00 : upd_i.cntr - 2'b01;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (upd_i.valid) begin
            mem_q[wr_idx][wr_way] <= '{tag:    wr_tag,
                                       target: upd_i.target[31:2],
                                       btype:  upd_i.btype,
                                       cntr:   wr_cntr};
        end else begin
            pred_o.hit    <= |rd_match;
            pred_o.target <= rd_entry.target;
            pred_o.way    <= rd_way;
            pred_o.cntr   <= rd_entry.cntr;
            pred_o.btype  <= rd_entry.btype;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (reset_i) begin
            for (int s = 0; s < BTB_SETS; s++) begin
                valid_q[s] <= 2'b00;
                repl_q[s]  <= 1'b0;
            end
        end else if (upd_i.valid) begin
            valid_q[wr_idx][wr_way] <= 1'b1;
            repl_q[wr_idx]          <= !wr_way;
        end
    end

endmodule

`default_nettype wire

/* logic/branch_pkg.sv */
`default_nettype none

package branch_pkg;

    typedef logic [31:0] word_t;
    typedef logic [29:0] pc_word_t;    // Byte address bits [31:2]
    typedef logic [5:0]  rob_id_t;
    typedef logic [5:0]  preg_t;       // Zero means no write
    typedef logic [1:0]  bm_cntr_t;    // Top bit is the taken prediction
    typedef logic [1:0]  btype_t;

    localparam btype_t BTYPE_COND = 2'd0;
    localparam btype_t BTYPE_JUMP = 2'd2;

    typedef struct packed {
        word_t    operand_1;
        word_t    operand_2;
        word_t    offset;
        pc_word_t pc;
        logic     auipc;
        logic     lui;
        logic     jal;
        logic     jalr;
        logic [2:0] bnch_cond;         // funct3
        rob_id_t  rob_id;
        preg_t    dest;
    } branch_op_t;

    typedef struct packed {
        logic     hit;
        pc_word_t target;
        logic     way;
        bm_cntr_t cntr;
        btype_t   btype;
    } btb_pred_t;

    typedef struct packed {
        word_t    result;
        logic     wb_valid;
        preg_t    dest;
        rob_id_t  rob_id;
        logic     excp;                // Mispredicted
    } resolve_t;

    typedef struct packed {
        logic     valid;
        pc_word_t vpc;
        word_t    target;              // Taken target
        logic     taken;
        btype_t   btype;
        logic     way;
        bm_cntr_t cntr;                // Counter as predicted
    } btb_update_t;

endpackage

`default_nettype wire
